// File: Bender.yml
package:
  name: data_mem

sources:
  # design, package first
  - src/mem_pkg.sv
  - src/access_decode.sv
  - src/data_ram.sv
  - src/load_extract.sv
  - src/data_mem_top.sv

  # testbench, top module data_mem_tb
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/data_mem_tb.sv

// File: compile.f
src/mem_pkg.sv
src/access_decode.sv
src/data_ram.sv
src/load_extract.sv
src/data_mem_top.sv
dv/tb_clock.sv
dv/data_mem_tb.sv

// File: dv/data_mem_tb.sv
module data_mem_tb;

  // cycles allowed for a load reply
  localparam int reply_timeout = 8;

  logic                       clk;
  logic                       reset;
  logic [mem_pkg::data_w-1:0] addr;
  logic                       we;
  logic                       re;
  mem_pkg::access_size_e      size;
  logic                       sign;
  logic [mem_pkg::data_w-1:0] wdata;
  logic [mem_pkg::data_w-1:0] rdata;
  logic                       rdata_valid;
  logic                       misaligned;

  // reference bytes indexed by byte address mod 4096
  logic [7:0]  model [int unsigned];
  logic [31:0] lcg_state = 32'h8f3b05a2;

  tb_clock u_clock (.clk(clk), .reset(reset));

  data_mem_top uut (
    .clk(clk), .reset(reset), .addr(addr), .we(we), .re(re), .size(size), .sign(sign),
    .wdata(wdata), .rdata(rdata), .rdata_valid(rdata_valid), .misaligned(misaligned)
  );

  ////////////////////////////////////////////////////////////////////////////
  // stimulus values and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] rand_aligned();
    return next_rand() & 32'hffff_fffc;
  endfunction

  // halfwords need an even address, words a multiple of four
  function automatic logic is_misaligned(logic [31:0] a, mem_pkg::access_size_e sz);
    if (sz == mem_pkg::size_half)
      return a[0];
    if (sz == mem_pkg::size_word)
      return a[1:0] != 2'b00;
    return 1'b0;
  endfunction

  function automatic logic [7:0] model_byte(logic [31:0] a);
    if (model.exists(a & 32'hfff))
      return model[a & 32'hfff];
    return 8'hxx;
  endfunction

  // little endian with the store value right justified
  function automatic void model_store(logic [31:0] a, mem_pkg::access_size_e sz, logic [31:0] d);
    int n;
    n = (sz == mem_pkg::size_byte) ? 1 : (sz == mem_pkg::size_half) ? 2 : 4;
    for (int i = 0; i < n; i++)
      model[(a + i) & 32'hfff] = d[8*i +: 8];
  endfunction

  // predicted reply built from the model bytes
  function automatic logic [31:0] expect_load(logic [31:0] a, mem_pkg::access_size_e sz,
                                              logic sg);
    logic [7:0]  b;
    logic [15:0] h;
    b = model_byte(a);
    h = {model_byte(a + 1), model_byte(a)};
    case (sz)
      mem_pkg::size_byte: return sg ? {{24{b[7]}}, b} : {24'h0, b};
      mem_pkg::size_half: return sg ? {{16{h[15]}}, h} : {16'h0, h};
      default: return {model_byte(a + 3), model_byte(a + 2), h};
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare and drive helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic stop_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_data(string name, logic [mem_pkg::data_w-1:0] exp,
                            logic [mem_pkg::data_w-1:0] act);
    if (act !== exp)
    begin
      $display("FAIL time %0t: %s expected %h, got %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp)
    begin
      $display("FAIL time %0t: %s expected %b, got %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  // new request just after the rising edge
  task automatic drive(logic [31:0] a, logic w, logic r, mem_pkg::access_size_e sz,
                       logic sg, logic [31:0] d);
    @(posedge clk);
    addr  <= a;
    we    <= w;
    re    <= r;
    size  <= sz;
    sign  <= sg;
    wdata <= d;
  endtask

  task automatic idle();
    drive('0, 1'b0, 1'b0, mem_pkg::size_word, 1'b0, '0);
  endtask

  // count of idle cycles before the reply where 0 means on time
  task automatic wait_reply(output int waited);
    int  n;
    logic got;
    n   = 0;
    got = 1'b0;
    while (!got && n < reply_timeout)
    begin
      @(negedge clk);
      if (rdata_valid)
        got = 1'b1;
      else
        n++;
    end
    waited = n;
    if (!got)
    begin
      $display("no load reply arrived within %0d cycles, time %0t", reply_timeout, $time);
      stop_run();
    end
  endtask

  // flag checked in the request cycle, model follows good stores only
  task automatic store_check(logic [31:0] a, mem_pkg::access_size_e sz, logic [31:0] d);
    drive(a, 1'b1, 1'b0, sz, 1'b0, d);
    @(negedge clk);
    check_flag("misaligned", is_misaligned(a, sz), misaligned);
    if (!is_misaligned(a, sz))
      model_store(a, sz, d);
  endtask

  task automatic load_check(logic [31:0] a, mem_pkg::access_size_e sz, logic sg);
    logic [31:0] exp;
    int          waited;
    exp = expect_load(a, sz, sg);
    drive(a, 1'b0, 1'b1, sz, sg, '0);
    @(negedge clk);
    check_flag("misaligned", 1'b0, misaligned);
    idle();
    // reply due in the very next cycle
    wait_reply(waited);
    if (waited != 0)
    begin
      $display("load reply came %0d cycles late, time %0t", waited, $time);
      stop_run();
    end
    check_data("rdata", exp, rdata);
  endtask

  // faulted load flags now and stays silent for the whole window
  task automatic bad_load_check(logic [31:0] a, mem_pkg::access_size_e sz);
    drive(a, 1'b0, 1'b1, sz, 1'b1, '0);
    @(negedge clk);
    check_flag("misaligned", 1'b1, misaligned);
    idle();
    for (int n = 0; n < reply_timeout; n++)
    begin
      @(negedge clk);
      check_flag("rdata_valid", 1'b0, rdata_valid);
      check_data("rdata", '0, rdata);
      check_flag("misaligned", 1'b0, misaligned);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    int n;
    // a load strobe while reset is high gets no reply
    drive('0, 1'b0, 1'b1, mem_pkg::size_word, 1'b0, '0);
    @(posedge clk);
    @(negedge clk);
    check_flag("rdata_valid", 1'b0, rdata_valid);
    idle();
    n = 0;
    while (reset && n < 32)
    begin
      @(posedge clk);
      n++;
    end
    if (reset)
    begin
      $display("reset was never released");
      stop_run();
    end
    @(negedge clk);
    check_flag("rdata_valid", 1'b0, rdata_valid);
    check_data("rdata", '0, rdata);
    check_flag("misaligned", 1'b0, misaligned);
  endtask

  task automatic word_traffic();
    logic [31:0] addrs [8];
    logic [31:0] exp [8];
    for (int i = 0; i < 8; i++)
    begin
      addrs[i] = rand_aligned();
      store_check(addrs[i], mem_pkg::size_word, next_rand());
    end
    for (int i = 0; i < 8; i++)
      load_check(addrs[i], mem_pkg::size_word, 1'b0);
    // back to back loads give one reply per cycle
    for (int i = 0; i < 8; i++)
      exp[i] = expect_load(addrs[i], mem_pkg::size_word, 1'b0);
    for (int i = 0; i <= 8; i++)
    begin
      if (i < 8)
        drive(addrs[i], 1'b0, 1'b1, mem_pkg::size_word, 1'b0, '0);
      else
        idle();
      if (i > 0)
      begin
        @(negedge clk);
        check_flag("rdata_valid", 1'b1, rdata_valid);
        check_data("rdata", exp[i-1], rdata);
      end
    end
    // bus back at zero once the burst drains
    idle();
    @(negedge clk);
    check_flag("rdata_valid", 1'b0, rdata_valid);
    check_data("rdata", '0, rdata);
  endtask

  task automatic sub_word_stores();
    logic [31:0] base;
    base = rand_aligned();
    store_check(base, mem_pkg::size_word, next_rand());
    // one byte lane at a time
    for (int off = 0; off < 4; off++)
    begin
      store_check(base + off, mem_pkg::size_byte, next_rand());
      load_check(base, mem_pkg::size_word, 1'b0);
    end
    // low then high halfword
    store_check(base, mem_pkg::size_half, next_rand());
    load_check(base, mem_pkg::size_word, 1'b0);
    store_check(base + 2, mem_pkg::size_half, next_rand());
    load_check(base, mem_pkg::size_word, 1'b0);
  endtask

  task automatic load_extension();
    logic [31:0] base;
    base = rand_aligned();
    // top bits of bytes are 1 0 0 1 and of halves 0 and 1
    store_check(base, mem_pkg::size_word, 32'h807f_01ff);
    for (int sg = 0; sg < 2; sg++)
    begin
      for (int off = 0; off < 4; off++)
        load_check(base + off, mem_pkg::size_byte, sg[0]);
      load_check(base, mem_pkg::size_half, sg[0]);
      load_check(base + 2, mem_pkg::size_half, sg[0]);
    end
  endtask

  task automatic misaligned_access();
    logic [31:0] base;
    base = rand_aligned();
    store_check(base, mem_pkg::size_word, next_rand());
    // faulted stores must leave the word alone
    store_check(base + 1, mem_pkg::size_half, next_rand());
    store_check(base + 3, mem_pkg::size_half, next_rand());
    for (int off = 1; off < 4; off++)
      store_check(base + off, mem_pkg::size_word, next_rand());
    load_check(base, mem_pkg::size_word, 1'b0);
    bad_load_check(base + 1, mem_pkg::size_half);
    bad_load_check(base + 3, mem_pkg::size_half);
    for (int off = 1; off < 4; off++)
      bad_load_check(base + off, mem_pkg::size_word);
  endtask

  task automatic read_first();
    logic [31:0] base;
    logic [31:0] old_word;
    logic [31:0] new_word;
    int          waited;
    base = rand_aligned();
    store_check(base, mem_pkg::size_word, next_rand());
    old_word = expect_load(base, mem_pkg::size_word, 1'b0);
    new_word = next_rand();
    // load and store to one word in the same cycle
    drive(base, 1'b1, 1'b1, mem_pkg::size_word, 1'b0, new_word);
    @(negedge clk);
    check_flag("misaligned", 1'b0, misaligned);
    model_store(base, mem_pkg::size_word, new_word);
    idle();
    wait_reply(waited);
    if (waited != 0)
    begin
      $display("read first reply came %0d cycles late, time %0t", waited, $time);
      stop_run();
    end
    check_data("rdata", old_word, rdata);
    load_check(base, mem_pkg::size_word, 1'b0);
  endtask

  initial
  begin
    addr  = '0;
    we    = 1'b0;
    re    = 1'b0;
    size  = mem_pkg::size_word;
    sign  = 1'b0;
    wdata = '0;
    reset_state();
    word_traffic();
    sub_word_stores();
    load_extension();
    misaligned_access();
    read_first();
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: dv/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic reset
);

  // free running clock, period 4
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset held high for the first 8 rising edges
  initial
  begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// File: src/access_decode.sv
module access_decode (
  input  logic [mem_pkg::data_w-1:0]      addr,
  input  logic [mem_pkg::data_w-1:0]      wdata,
  input  logic                            we,
  input  logic                            re,
  input  mem_pkg::access_size_e           size,
  output logic                            misaligned,
  output logic [mem_pkg::byte_lanes-1:0]  byte_we,
  output logic [mem_pkg::data_w-1:0]      lane_wdata,
  output logic [mem_pkg::word_addr_w-1:0] word_addr,
  output logic                            rd_en,
  output logic [1:0]                      offset
);

  // any strobe makes this a request
  logic req;
  // size code names a real access
  logic size_ok;
  // alignment fault before strobe gating
  logic align_err;
  // lanes touched by the access
  logic [mem_pkg::byte_lanes-1:0] lane_mask;

  assign req = we | re;

  // byte position inside the word
  assign offset = addr[1:0];

  // word index, upper bits dropped so the RAM wraps
  assign word_addr = addr[mem_pkg::word_addr_w+1:2];

  ////////////////////////////////////////////////////////////////////////////
  // size decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    size_ok    = 1'b1;
    align_err  = 1'b0;
    lane_mask  = '0;
    lane_wdata = wdata;
    case (size)
      mem_pkg::size_byte:
      begin
        // one lane, store byte copied to every lane
        lane_mask  = 4'b0001 << addr[1:0];
        lane_wdata = {mem_pkg::byte_lanes{wdata[mem_pkg::byte_w-1:0]}};
      end
      mem_pkg::size_half:
      begin
        // odd byte address cannot hold a halfword
        align_err  = addr[0];
        lane_mask  = addr[1] ? 4'b1100 : 4'b0011;
        lane_wdata = {2{wdata[2*mem_pkg::byte_w-1:0]}};
      end
      mem_pkg::size_word:
      begin
        // words only on a 4 byte boundary
        align_err  = (addr[1:0] != 2'b00);
        lane_mask  = '1;
        lane_wdata = wdata;
      end
      default:
      begin
        // unused code, no lanes and no read
        size_ok = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // strobe gating
  ////////////////////////////////////////////////////////////////////////////

  // flag only while a request is present
  assign misaligned = req & align_err;

  // faulted stores write nothing
  assign byte_we = (we && !align_err) ? lane_mask : '0;

  // faulted or unsized loads never reach the RAM
  assign rd_en = re & size_ok & ~align_err;

endmodule

// File: src/data_mem_top.sv
module data_mem_top (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [mem_pkg::data_w-1:0] addr,
  input  logic                       we,
  input  logic                       re,
  input  mem_pkg::access_size_e      size,
  input  logic                       sign,
  input  logic [mem_pkg::data_w-1:0] wdata,
  output logic [mem_pkg::data_w-1:0] rdata,
  output logic                       rdata_valid,
  output logic                       misaligned
);

  // decode to RAM
  logic [mem_pkg::byte_lanes-1:0]  byte_we;
  logic [mem_pkg::data_w-1:0]      lane_wdata;
  logic [mem_pkg::word_addr_w-1:0] word_addr;

  // decode to extract
  logic                            rd_en;
  logic [1:0]                      offset;

  // RAM to extract
  logic [mem_pkg::data_w-1:0]      rd_word;

  ////////////////////////////////////////////////////////////////////////////
  // request decode, storage, load reply
  ////////////////////////////////////////////////////////////////////////////

  access_decode u_access_decode (
    .addr       (addr),
    .wdata      (wdata),
    .we         (we),
    .re         (re),
    .size       (size),
    .misaligned (misaligned),
    .byte_we    (byte_we),
    .lane_wdata (lane_wdata),
    .word_addr  (word_addr),
    .rd_en      (rd_en),
    .offset     (offset)
  );

  data_ram u_data_ram (
    .clk        (clk),
    .byte_we    (byte_we),
    .word_addr  (word_addr),
    .lane_wdata (lane_wdata),
    .rd_en      (rd_en),
    .rd_word    (rd_word)
  );

  // size and sign come straight from the request port
  load_extract u_load_extract (
    .clk         (clk),
    .reset       (reset),
    .rd_en       (rd_en),
    .offset      (offset),
    .size        (size),
    .sign        (sign),
    .rd_word     (rd_word),
    .rdata       (rdata),
    .rdata_valid (rdata_valid)
  );

endmodule

// File: src/data_ram.sv
module data_ram (
  input  logic                            clk,
  input  logic [mem_pkg::byte_lanes-1:0]  byte_we,
  input  logic [mem_pkg::word_addr_w-1:0] word_addr,
  input  logic [mem_pkg::data_w-1:0]      lane_wdata,
  input  logic                            rd_en,
  output logic [mem_pkg::data_w-1:0]      rd_word
);

  // block RAM style word array
  logic [mem_pkg::data_w-1:0] mem [mem_pkg::ram_depth];

  ////////////////////////////////////////////////////////////////////////////
  // byte enabled write port
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    for (int i = 0; i < mem_pkg::byte_lanes; i++)
    begin
      // each enable bit owns one byte of the word
      if (byte_we[i])
        mem[word_addr][i*mem_pkg::byte_w +: mem_pkg::byte_w] <=
          lane_wdata[i*mem_pkg::byte_w +: mem_pkg::byte_w];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registered read
  ////////////////////////////////////////////////////////////////////////////

  // old contents come out when read and write share a cycle
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_word <= mem[word_addr];
  end

endmodule

// File: src/load_extract.sv
module load_extract (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       rd_en,
  input  logic [1:0]                 offset,
  input  mem_pkg::access_size_e      size,
  input  logic                       sign,
  input  logic [mem_pkg::data_w-1:0] rd_word,
  output logic [mem_pkg::data_w-1:0] rdata,
  output logic                       rdata_valid
);

  // load attributes held across the RAM latency
  logic                  valid_q;
  logic [1:0]            offset_q;
  mem_pkg::access_size_e size_q;
  logic                  sign_q;

  // lanes picked out of the read word
  logic [mem_pkg::byte_w-1:0]   sel_byte;
  logic [2*mem_pkg::byte_w-1:0] sel_half;
  // extended result before valid gating
  logic [mem_pkg::data_w-1:0]   ext_word;

  ////////////////////////////////////////////////////////////////////////////
  // request capture
  ////////////////////////////////////////////////////////////////////////////

  // one cycle reply pulse per accepted load
  always_ff @(posedge clk)
  begin
    if (reset)
      valid_q <= 1'b0;
    else
      valid_q <= rd_en;
  end

  // attributes follow the load into the reply cycle
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      offset_q <= offset;
      size_q   <= size;
      sign_q   <= sign;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lane select and extension
  ////////////////////////////////////////////////////////////////////////////

  // byte at offset, halfword from the low or high pair
  assign sel_byte = rd_word[{offset_q, 3'b000} +: mem_pkg::byte_w];
  assign sel_half = offset_q[1] ? rd_word[mem_pkg::data_w-1:2*mem_pkg::byte_w]
                                : rd_word[2*mem_pkg::byte_w-1:0];

  always_comb
  begin
    case (size_q)
      mem_pkg::size_byte:
        ext_word = {{(mem_pkg::data_w-mem_pkg::byte_w){sign_q & sel_byte[mem_pkg::byte_w-1]}},
                    sel_byte};
      mem_pkg::size_half:
        ext_word = {{(mem_pkg::data_w-2*mem_pkg::byte_w){sign_q & sel_half[2*mem_pkg::byte_w-1]}},
                    sel_half};
      // whole word passes as read
      mem_pkg::size_word:
        ext_word = rd_word;
      default:
        ext_word = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // reply outputs
  ////////////////////////////////////////////////////////////////////////////

  assign rdata_valid = valid_q;

  // bus idles at zero between replies
  assign rdata = valid_q ? ext_word : '0;

endmodule

// File: src/mem_pkg.sv
package mem_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // word and lane geometry
  ////////////////////////////////////////////////////////////////////////////

  // width of one data word
  localparam int data_w = 32;

  // byte lanes per word
  localparam int byte_lanes = 4;

  // bits in one lane
  localparam int byte_w = data_w / byte_lanes;

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // words held in the data RAM
  localparam int ram_depth = 1024;

  // word index width, addresses wrap past this
  localparam int word_addr_w = 10;

  ////////////////////////////////////////////////////////////////////////////
  // access width of a load or store
  ////////////////////////////////////////////////////////////////////////////

  // code 2'b11 stays unused and means no access
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } access_size_e;

endpackage
